// File: design/csr_ctrl.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_ctrl (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   input  logic                      i_req,
   input  csr_pkg::csr_cmd_e         i_cmd,
   input  logic [`CSR_ADDR_W-1:0]    i_addr,
   input  logic [`CSR_XLEN-1:0]      i_wdata,
   input  csr_pkg::trap_kind_e       i_trap_kind,
   input  logic                      i_q,          // old csr bit, lsb first
   output logic                      o_ack,
   output logic [`CSR_XLEN-1:0]      o_rdata,
   output logic                      o_en,
   output logic [`CSR_CNT_W-1:0]     o_cnt,
   output csr_pkg::csr_src_e         o_src,
   output logic                      o_d,
   output logic                      o_mstatus_en,
   output logic                      o_mie_en,
   output logic                      o_mcause_en,
   output logic                      o_misa_en,
   output logic                      o_dcsr_en,
   output logic                      o_store_en,
   output logic [1:0]                o_store_sel,
   output logic                      o_trap,
   output logic                      o_mret,
   output logic                      o_dret,
   output logic                      o_e_op,
   output logic                      o_ebreak,
   output logic                      o_mem_op,
   output logic                      o_mem_cmd
);

   csr_pkg::ctrl_state_e        state;
   csr_pkg::csr_cmd_e           cmd_q;
   csr_pkg::trap_kind_e         kind_q;
   logic [`CSR_ADDR_W-1:0]      addr_q;
   logic [`CSR_XLEN-1:0]        op_sr;    // operand, shifted out lsb first
   logic                        accept;
   logic                        last;
   logic                        is_trap;

   assign accept = (state == csr_pkg::ST_IDLE) & i_req;
   assign o_en   = (state == csr_pkg::ST_RUN);
   assign o_ack  = (state == csr_pkg::ST_DONE);
   assign last   = o_en & (&o_cnt);          // bit 31
   assign o_d    = op_sr[0];

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= csr_pkg::ST_IDLE;
         o_cnt <= '0;
      end else begin
         case (state)
            csr_pkg::ST_IDLE: begin
               o_cnt <= '0;
               if (i_req)
                  state <= csr_pkg::ST_RUN;
            end
            csr_pkg::ST_RUN: begin
               o_cnt <= o_cnt + 1'b1;            // wraps back to 0 after bit 31
               if (&o_cnt)
                  state <= csr_pkg::ST_DONE;
            end
            csr_pkg::ST_DONE: if (!i_req) state <= csr_pkg::ST_IDLE;   // host let go
            default: state <= csr_pkg::ST_IDLE;
         endcase
      end
   end

   // command payload and the two serial shifters
   always_ff @(posedge i_clk) begin
      if (accept) begin
         cmd_q  <= i_cmd;
         addr_q <= i_addr;
         kind_q <= i_trap_kind;
         op_sr  <= i_wdata;
      end else if (o_en) begin
         op_sr   <= op_sr >> 1;
         o_rdata <= {i_q, o_rdata[`CSR_XLEN-1:1]};   // deserialize, msb enters last
      end
   end

   assign is_trap = (cmd_q == csr_pkg::CMD_TRAP);

   always_comb begin
      case (cmd_q)
         csr_pkg::CMD_CSRRW: o_src = csr_pkg::SRC_EXT;
         csr_pkg::CMD_CSRRS: o_src = csr_pkg::SRC_SET;
         csr_pkg::CMD_CSRRC: o_src = csr_pkg::SRC_CLR;
         default:            o_src = csr_pkg::SRC_CSR;   // trap and returns leave csrs alone
      endcase
   end

   // one csr enable from the address, trap reads mtvec
   always_comb begin
      o_mstatus_en = 1'b0;
      o_mie_en     = 1'b0;
      o_mcause_en  = 1'b0;
      o_misa_en    = 1'b0;
      o_dcsr_en    = 1'b0;
      o_store_en   = 1'b0;
      o_store_sel  = `CSR_SEL_MSCRATCH;
      if (is_trap) begin
         o_store_en  = 1'b1;
         o_store_sel = `CSR_SEL_MTVEC;          // mepc write rides on o_trap
      end else begin
         case (addr_q)
            `CSR_A_MSTATUS:  o_mstatus_en = 1'b1;
            `CSR_A_MISA:     o_misa_en    = 1'b1;
            `CSR_A_MIE:      o_mie_en     = 1'b1;
            `CSR_A_MCAUSE:   o_mcause_en  = 1'b1;
            `CSR_A_DCSR:     o_dcsr_en    = 1'b1;
            `CSR_A_MSCRATCH: o_store_en   = 1'b1;
            `CSR_A_MTVEC: begin
               o_store_en  = 1'b1;
               o_store_sel = `CSR_SEL_MTVEC;
            end
            `CSR_A_MEPC: begin
               o_store_en  = 1'b1;
               o_store_sel = `CSR_SEL_MEPC;
            end
            default: ;                          // unmapped, reads zero
         endcase
      end
   end

   // trap is held over the whole pass so mepc can load the pc
   assign o_trap    = o_en & is_trap;
   assign o_mret    = last & (cmd_q == csr_pkg::CMD_MRET);
   assign o_dret    = last & (cmd_q == csr_pkg::CMD_DRET);
   assign o_ebreak  = o_trap & (kind_q == csr_pkg::TK_EBREAK);
   assign o_e_op    = o_trap & ((kind_q == csr_pkg::TK_ECALL) | (kind_q == csr_pkg::TK_EBREAK));
   assign o_mem_cmd = o_trap & (kind_q == csr_pkg::TK_STORE);
   assign o_mem_op  = o_trap & ((kind_q == csr_pkg::TK_LOAD) | (kind_q == csr_pkg::TK_STORE));

endmodule

// File: design/csr_pkg.sv
package csr_pkg;

   // host commands
   typedef enum logic [2:0] {
      CMD_CSRRW = 3'd0,   // plain write
      CMD_CSRRS = 3'd1,   // set bits
      CMD_CSRRC = 3'd2,   // clear bits
      CMD_TRAP  = 3'd3,   // operand is trap pc
      CMD_MRET  = 3'd4,
      CMD_DRET  = 3'd5
   } csr_cmd_e;

   // per-bit source of the new csr bit
   typedef enum logic [1:0] {
      SRC_CSR = 2'b00,    // keep old bit
      SRC_EXT = 2'b01,
      SRC_SET = 2'b10,
      SRC_CLR = 2'b11
   } csr_src_e;

   typedef enum logic [2:0] {
      TK_IRQ    = 3'd0,
      TK_ECALL  = 3'd1,
      TK_EBREAK = 3'd2,
      TK_LOAD   = 3'd3,   // misaligned load
      TK_STORE  = 3'd4,   // misaligned store
      TK_JUMP   = 3'd5    // misaligned jump
   } trap_kind_e;

   typedef enum logic [1:0] {
      ST_IDLE,            // waiting for req
      ST_RUN,             // 32 bit cycles
      ST_DONE             // ack high until req drops
   } ctrl_state_e;

endpackage

// File: design/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// datapath and counter widths, xlen must equal 2**cnt_w
`define CSR_XLEN   32
`define CSR_CNT_W  5
`define CSR_ADDR_W 12

// machine and debug csr addresses
`define CSR_A_MSTATUS  12'h300
`define CSR_A_MISA     12'h301
`define CSR_A_MIE      12'h304
`define CSR_A_MTVEC    12'h305
`define CSR_A_MSCRATCH 12'h340
`define CSR_A_MEPC     12'h341
`define CSR_A_MCAUSE   12'h342
`define CSR_A_DCSR     12'h7B0

// csr_store register select codes
`define CSR_SEL_MSCRATCH 2'd0
`define CSR_SEL_MTVEC    2'd1
`define CSR_SEL_MEPC     2'd2

`endif

// File: design/csr_store.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_store (
   input  logic        i_clk,
   input  logic        i_rst_n,
   input  logic        i_en,
   input  logic        i_store_en,
   input  logic [1:0]  i_store_sel,
   input  logic        i_trap,
   input  logic        i_d,          // operand bit, trap pc on a trap
   input  logic        i_csr_in,     // new bit from serial_csr
   output logic        o_rf_bit
);

   logic [`CSR_XLEN-1:0] mscratch;
   logic [`CSR_XLEN-1:0] mtvec;
   logic [`CSR_XLEN-1:0] mepc;
   logic                 sel_mscratch;
   logic                 sel_mtvec;
   logic                 sel_mepc;

   // one step of rotate right, new bit enters at the top
   function automatic logic [`CSR_XLEN-1:0] rot(input logic [`CSR_XLEN-1:0] r,
                                                input logic wr,
                                                input logic b);
      rot = {(wr ? b : r[0]), r[`CSR_XLEN-1:1]};
   endfunction

   assign sel_mscratch = i_store_en & (i_store_sel == `CSR_SEL_MSCRATCH);
   assign sel_mtvec    = i_store_en & (i_store_sel == `CSR_SEL_MTVEC);
   assign sel_mepc     = i_store_en & (i_store_sel == `CSR_SEL_MEPC);

   // current bit of whichever register is addressed
   assign o_rf_bit = (sel_mscratch & mscratch[0]) |
                     (sel_mtvec & mtvec[0])       |
                     (sel_mepc & mepc[0]);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mscratch <= '0;
         mtvec    <= '0;
         mepc     <= '0;
      end else if (i_en) begin
         // all three rotate so they stay aligned with the bit counter
         mscratch <= rot(mscratch, sel_mscratch, i_csr_in);
         mtvec    <= rot(mtvec, sel_mtvec, i_csr_in);      // on trap csr_in is its own bit
         if (i_trap)
            mepc <= rot(mepc, 1'b1, i_d);                  // capture trap pc
         else
            mepc <= rot(mepc, sel_mepc, i_csr_in);
      end
   end

endmodule

// File: design/csr_top.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_top (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  logic                    i_req,
   input  csr_pkg::csr_cmd_e       i_cmd,
   input  logic [`CSR_ADDR_W-1:0]  i_addr,
   input  logic [`CSR_XLEN-1:0]    i_wdata,
   input  csr_pkg::trap_kind_e     i_trap_kind,
   input  logic                    i_mtip,
   input  logic                    i_dbg_halt,
   input  logic                    i_dbg_reset,
   output logic                    o_ack,
   output logic [`CSR_XLEN-1:0]    o_rdata,
   output logic                    o_new_irq,
   output logic                    o_dbg_step
);

   logic                   en;
   logic [`CSR_CNT_W-1:0]  cnt;
   csr_pkg::csr_src_e      src;
   logic                   d;
   logic                   mstatus_en, mie_en, mcause_en, misa_en, dcsr_en;
   logic                   store_en;
   logic [1:0]             store_sel;
   logic                   trap, mret, dret;
   logic                   e_op, ebreak, mem_op, mem_cmd;   // trap kind decode
   logic                   q;          // old bit back to the controller
   logic                   csr_in;     // new bit into csr_store
   logic                   rf_bit;

   csr_ctrl u_ctrl (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_cmd(i_cmd),
      .i_addr(i_addr), .i_wdata(i_wdata), .i_trap_kind(i_trap_kind), .i_q(q),
      .o_ack(o_ack), .o_rdata(o_rdata), .o_en(en), .o_cnt(cnt), .o_src(src), .o_d(d),
      .o_mstatus_en(mstatus_en), .o_mie_en(mie_en), .o_mcause_en(mcause_en),
      .o_misa_en(misa_en), .o_dcsr_en(dcsr_en), .o_store_en(store_en),
      .o_store_sel(store_sel), .o_trap(trap), .o_mret(mret), .o_dret(dret),
      .o_e_op(e_op), .o_ebreak(ebreak), .o_mem_op(mem_op), .o_mem_cmd(mem_cmd)
   );

   serial_csr u_csr (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_dbg_halt(i_dbg_halt),
      .i_dbg_reset(i_dbg_reset), .i_en(en), .i_cnt(cnt), .i_mtip(i_mtip),
      .i_trap(trap), .i_mret(mret), .i_dret(dret), .i_e_op(e_op), .i_ebreak(ebreak),
      .i_mem_op(mem_op), .i_mem_cmd(mem_cmd), .i_mstatus_en(mstatus_en),
      .i_mie_en(mie_en), .i_mcause_en(mcause_en), .i_misa_en(misa_en),
      .i_dcsr_en(dcsr_en), .i_src(src), .i_d(d), .i_rf_bit(rf_bit),
      .o_q(q), .o_csr_in(csr_in), .o_new_irq(o_new_irq), .o_dbg_step(o_dbg_step)
   );

   csr_store u_store (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en(en), .i_store_en(store_en),
      .i_store_sel(store_sel), .i_trap(trap), .i_d(d), .i_csr_in(csr_in),
      .o_rf_bit(rf_bit)
   );

endmodule

// File: design/serial_csr.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module serial_csr (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_dbg_halt,
   input  logic                   i_dbg_reset,
   input  logic                   i_en,
   input  logic [`CSR_CNT_W-1:0]  i_cnt,
   input  logic                   i_mtip,
   input  logic                   i_trap,
   input  logic                   i_mret,
   input  logic                   i_dret,
   input  logic                   i_e_op,
   input  logic                   i_ebreak,
   input  logic                   i_mem_op,
   input  logic                   i_mem_cmd,
   input  logic                   i_mstatus_en,
   input  logic                   i_mie_en,
   input  logic                   i_mcause_en,
   input  logic                   i_misa_en,
   input  logic                   i_dcsr_en,
   input  csr_pkg::csr_src_e      i_src,
   input  logic                   i_d,
   input  logic                   i_rf_bit,     // bit from csr_store
   output logic                   o_q,
   output logic                   o_csr_in,
   output logic                   o_new_irq,
   output logic                   o_dbg_step
);

   logic        mstatus_mie;
   logic        mstatus_mpie;     // not visible to software
   logic        mie_mtie;
   logic        mcause31;
   logic [3:0]  mcause3_0;
   logic        mcause_bit;
   logic        dcsr_step;
   logic        dcsr_ebreakm;
   logic [2:0]  dcsr_cause;
   logic        timer_irq;
   logic        timer_irq_r;
   logic        clr;              // reset or debug reset
   logic        csr_out;
   logic        cnt0to3, cnt2, cnt3, cnt4, cnt6, cnt7, cnt8, cnt15, cnt30, cnt_done;

   function automatic logic at_bit(input logic [`CSR_CNT_W-1:0] cnt, input int unsigned n);
      at_bit = (cnt == n[`CSR_CNT_W-1:0]);
   endfunction

   // bit strobes, only live during a run
   assign cnt0to3  = i_en & (i_cnt[`CSR_CNT_W-1:2] == '0);
   assign cnt2     = i_en & at_bit(i_cnt, 2);
   assign cnt3     = i_en & at_bit(i_cnt, 3);
   assign cnt4     = i_en & at_bit(i_cnt, 4);
   assign cnt6     = i_en & at_bit(i_cnt, 6);
   assign cnt7     = i_en & at_bit(i_cnt, 7);
   assign cnt8     = i_en & at_bit(i_cnt, 8);
   assign cnt15    = i_en & at_bit(i_cnt, 15);
   assign cnt30    = i_en & at_bit(i_cnt, 30);
   assign cnt_done = i_en & (&i_cnt);

   assign clr = !i_rst_n | i_dbg_reset;

   assign mcause_bit = cnt0to3  ? mcause3_0[0] :    // low code bits
                       cnt_done ? mcause31 : 1'b0;   // interrupt flag

   assign csr_out = (i_mstatus_en & cnt3 & mstatus_mie)  |
                    (i_mie_en & cnt7 & mie_mtie)         |
                    (i_misa_en & cnt4)                   |   // E extension
                    (i_misa_en & cnt30)                  |   // mxl = 32 bit
                    (i_dcsr_en & cnt30)                  |   // debug spec 1.0
                    (i_dcsr_en & cnt15 & dcsr_ebreakm)   |
                    (i_dcsr_en & cnt8 & dcsr_cause[2])   |
                    (i_dcsr_en & cnt7 & dcsr_cause[1])   |
                    (i_dcsr_en & cnt6 & dcsr_cause[0])   |
                    (i_dcsr_en & cnt2 & dcsr_step)       |
                    (i_mcause_en & mcause_bit)           |
                    i_rf_bit;

   always_comb begin
      case (i_src)
         csr_pkg::SRC_EXT: o_csr_in = i_d;
         csr_pkg::SRC_SET: o_csr_in = csr_out | i_d;
         csr_pkg::SRC_CLR: o_csr_in = csr_out & ~i_d;
         default:          o_csr_in = csr_out;
      endcase
   end

   assign o_q        = csr_out;
   assign o_dbg_step = dcsr_step;
   assign timer_irq  = i_mtip & mstatus_mie & mie_mtie;

   always_ff @(posedge i_clk) begin
      if (clr) begin
         timer_irq_r  <= 1'b0;
         o_new_irq    <= 1'b0;
         mie_mtie     <= 1'b0;
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mcause3_0    <= 4'd0;
         mcause31     <= 1'b0;
         dcsr_step    <= 1'b0;
         dcsr_ebreakm <= 1'b0;
         dcsr_cause   <= 3'd0;
      end else begin
         if (cnt_done) begin
            timer_irq_r <= timer_irq;
            o_new_irq   <= timer_irq & !timer_irq_r;   // rising edge only
         end
         if (i_mie_en & cnt7)
            mie_mtie <= o_csr_in;
         // cleared on trap, restored on mret, written at bit 3, never together
         if ((i_trap & cnt_done) | (i_mstatus_en & cnt3) | i_mret)
            mstatus_mie <= !i_trap & (i_mret ? mstatus_mpie : o_csr_in);
         if (i_trap & cnt_done)
            mstatus_mpie <= mstatus_mie;
         // irq 0111, ebreak 0011, ecall 1011, load 0100, store 0110, jump 0000
         if (i_trap & cnt_done) begin
            mcause3_0[3] <= i_e_op & !i_ebreak;
            mcause3_0[2] <= o_new_irq | i_mem_op;
            mcause3_0[1] <= o_new_irq | i_e_op | (i_mem_op & i_mem_cmd);
            mcause3_0[0] <= o_new_irq | i_e_op;
            mcause31     <= o_new_irq;
         end else if (i_mcause_en & cnt0to3) begin
            mcause3_0 <= {o_csr_in, mcause3_0[3:1]};  // serial write of code
         end else if (i_mcause_en & cnt_done) begin
            mcause31 <= o_csr_in;
         end
         if (i_dcsr_en & cnt2)
            dcsr_step <= o_csr_in;
         if (i_dcsr_en & cnt15)
            dcsr_ebreakm <= o_csr_in;
         if (i_dbg_halt)
            dcsr_cause <= 3'b011;          // halt request wins
         else if (i_dret)
            dcsr_cause <= 3'b000;          // leaving debug mode
         else if (i_ebreak)
            dcsr_cause <= 3'b001;
         else if (dcsr_step)
            dcsr_cause <= 3'b100;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f vlog.f --top-module tb_csr_top -o sim_csr

# the simulator exit code is masked by tee, the log decides
./obj_dir/sim_csr | tee sim.log
grep -q "Verification passed" sim.log
echo "run.sh: simulation log shows a pass"

// File: verif/tb_csr_top.sv
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_top;

   localparam int N_CMDS = 80;                  // commands issued below, rounded up
   localparam int LIMIT  = 40 * N_CMDS + 100;   // cycles

   logic                    i_clk;
   logic                    i_rst_n;
   logic                    i_req;
   csr_pkg::csr_cmd_e       i_cmd;
   logic [`CSR_ADDR_W-1:0]  i_addr;
   logic [`CSR_XLEN-1:0]    i_wdata;
   csr_pkg::trap_kind_e     i_trap_kind;
   logic                    i_mtip;
   logic                    i_dbg_halt;
   logic                    i_dbg_reset;
   logic                    o_ack;
   logic [`CSR_XLEN-1:0]    o_rdata;
   logic                    o_new_irq;
   logic                    o_dbg_step;

   // model copies of the architectural bits
   logic        m_mie, m_mpie, m_mtie, m_mtip;
   logic        m_cause31, m_step, m_ebreakm;
   logic        m_tir, m_new_irq;               // irq edge detector
   logic [3:0]  m_code;
   logic [2:0]  m_dcause;
   logic [31:0] m_mscratch, m_mtvec, m_mepc;

   logic [31:0] exp_q[$];                       // expected rdata, one per command
   string       name_q[$];
   logic        ack_d = 1'b0;
   int          cycles = 0;
   integer      seed;

   csr_top i_csr_top (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_cmd(i_cmd), .i_addr(i_addr),
      .i_wdata(i_wdata), .i_trap_kind(i_trap_kind), .i_mtip(i_mtip),
      .i_dbg_halt(i_dbg_halt), .i_dbg_reset(i_dbg_reset), .o_ack(o_ack),
      .o_rdata(o_rdata), .o_new_irq(o_new_irq), .o_dbg_step(o_dbg_step)
   );

   always #4 i_clk = ~i_clk;

   function automatic logic [31:0] apply_op(input csr_pkg::csr_cmd_e cmd,
                                            input logic [31:0] old, input logic [31:0] d);
      case (cmd)
         csr_pkg::CMD_CSRRW: apply_op = d;
         csr_pkg::CMD_CSRRS: apply_op = old | d;
         csr_pkg::CMD_CSRRC: apply_op = old & ~d;
         default:            apply_op = old;    // trap and returns write nothing
      endcase
   endfunction

   function automatic logic [31:0] model_read(input logic [11:0] addr);
      case (addr)
         `CSR_A_MSTATUS:  model_read = {28'b0, m_mie, 3'b0};
         `CSR_A_MISA:     model_read = 32'h4000_0010;     // rv32e
         `CSR_A_MIE:      model_read = {24'b0, m_mtie, 7'b0};
         `CSR_A_MTVEC:    model_read = m_mtvec;
         `CSR_A_MSCRATCH: model_read = m_mscratch;
         `CSR_A_MEPC:     model_read = m_mepc;
         `CSR_A_MCAUSE:   model_read = {m_cause31, 27'b0, m_code};
         `CSR_A_DCSR:     model_read = {2'b01, 14'b0, m_ebreakm, 6'b0, m_dcause, 3'b0, m_step, 2'b0};
         default:         model_read = 32'h0;
      endcase
   endfunction

   // exception codes, irq only counts with an interrupt pending
   function automatic logic [3:0] trap_code(input csr_pkg::trap_kind_e kind);
      case (kind)
         csr_pkg::TK_ECALL:  trap_code = 4'd11;
         csr_pkg::TK_EBREAK: trap_code = 4'd3;
         csr_pkg::TK_LOAD:   trap_code = 4'd4;
         csr_pkg::TK_STORE:  trap_code = 4'd6;
         default:            trap_code = 4'd0;
      endcase
   endfunction

   function automatic csr_pkg::csr_cmd_e rmw_op(input logic [1:0] sel);
      case (sel)
         2'd1:    rmw_op = csr_pkg::CMD_CSRRS;
         2'd2:    rmw_op = csr_pkg::CMD_CSRRC;
         default: rmw_op = csr_pkg::CMD_CSRRW;
      endcase
   endfunction

   // returns the old value and moves the model to the state after the command
   function automatic logic [31:0] ref_csr(input csr_pkg::csr_cmd_e cmd, input logic [11:0] addr,
                                           input logic [31:0] wdata,
                                           input csr_pkg::trap_kind_e kind);
      logic [31:0] old;
      logic [31:0] nv;
      logic        ti;
      if (m_step)
         m_dcause = 3'd4;                       // step reloads cause every cycle
      if (cmd == csr_pkg::CMD_TRAP) begin
         old       = m_mtvec;
         m_mepc    = wdata;                     // operand is the trap pc
         m_cause31 = m_new_irq;
         m_code    = m_new_irq ? 4'd7 : trap_code(kind);
         if (kind == csr_pkg::TK_EBREAK)
            m_dcause = 3'd1;
         ti     = m_mtip & m_mie & m_mtie;      // sampled before mie clears
         m_mpie = m_mie;
         m_mie  = 1'b0;
      end else begin
         old = model_read(addr);
         nv  = apply_op(cmd, old, wdata);
         case (addr)
            `CSR_A_MSTATUS:  m_mie = nv[3];
            `CSR_A_MIE:      m_mtie = nv[7];
            `CSR_A_MSCRATCH: m_mscratch = nv;
            `CSR_A_MTVEC:    m_mtvec = nv;
            `CSR_A_MEPC:     m_mepc = nv;
            `CSR_A_MCAUSE: begin
               m_code    = nv[3:0];
               m_cause31 = nv[31];
            end
            `CSR_A_DCSR: begin
               if (nv[2] && !m_step)
                  old[8:6] = 3'd4;              // step lands at bit 2, cause read at 6..8
               m_step    = nv[2];
               m_ebreakm = nv[15];
            end
            default: ;
         endcase
         ti = m_mtip & m_mie & m_mtie;
         if (cmd == csr_pkg::CMD_MRET)
            m_mie = m_mpie;
         if (cmd == csr_pkg::CMD_DRET)
            m_dcause = 3'd0;
      end
      m_new_irq = ti & !m_tir;
      m_tir     = ti;
      if (m_step)
         m_dcause = 3'd4;
      ref_csr = old;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s expected %08h actual %08h", name, exp, act);
         $display("Verification failed");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   task automatic check_flags(input string name);
      check({name, " new_irq"}, {31'b0, m_new_irq}, {31'b0, o_new_irq});
      check({name, " dbg_step"}, {31'b0, m_step}, {31'b0, o_dbg_step});
   endtask

   // four-phase handshake, one command
   task automatic run_cmd(input string name, input csr_pkg::csr_cmd_e cmd,
                          input logic [11:0] addr, input logic [31:0] wdata,
                          input csr_pkg::trap_kind_e kind);
      logic [31:0] exp;
      exp = ref_csr(cmd, addr, wdata, kind);
      exp_q.push_back(exp);
      name_q.push_back(name);
      @(posedge i_clk);
      i_req       <= 1'b1;
      i_cmd       <= cmd;
      i_addr      <= addr;
      i_wdata     <= wdata;
      i_trap_kind <= kind;
      @(negedge i_clk);
      while (!o_ack) @(negedge i_clk);
      @(posedge i_clk);
      i_req <= 1'b0;
      @(negedge i_clk);
      while (o_ack) @(negedge i_clk);
   endtask

   task automatic read_csr(input string name, input logic [11:0] addr);
      run_cmd(name, csr_pkg::CMD_CSRRS, addr, 32'h0, csr_pkg::TK_IRQ);
   endtask

   task automatic write_csr(input string name, input logic [11:0] addr, input logic [31:0] d);
      run_cmd(name, csr_pkg::CMD_CSRRW, addr, d, csr_pkg::TK_IRQ);
   endtask

   task automatic drive_mtip(input logic v);
      @(posedge i_clk);
      i_mtip <= v;
      m_mtip = v;
   endtask

   task automatic pulse_halt;
      @(posedge i_clk);
      i_dbg_halt <= 1'b1;
      repeat (2) @(posedge i_clk);
      i_dbg_halt <= 1'b0;
      m_dcause = 3'd3;                          // halt request
      @(negedge i_clk);
   endtask

   task automatic pulse_dbg_reset;
      @(posedge i_clk);
      i_dbg_reset <= 1'b1;
      @(posedge i_clk);
      i_dbg_reset <= 1'b0;
      {m_mie, m_mpie, m_mtie, m_cause31, m_step, m_ebreakm, m_tir, m_new_irq} = '0;
      m_code   = '0;
      m_dcause = '0;
      @(negedge i_clk);
   endtask

   // compare on every rising ack
   always @(negedge i_clk) begin
      logic rise;
      rise  = o_ack && !ack_d;
      ack_d = o_ack;
      if (rise && exp_q.size() == 0) begin
         $display("ack seen with no command outstanding");
         $display("Verification failed");
         $fatal(1, "unexpected ack");
      end else if (rise) begin
         check(name_q.pop_front(), exp_q.pop_front(), o_rdata);
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout, the DUT stopped answering after %0d cycles", cycles);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      logic [31:0]         r;
      logic [31:0]         d;
      csr_pkg::trap_kind_e kind;
      seed        = 32'hdf894e9d;
      i_clk       = 1'b0;
      i_rst_n     = 1'b0;
      i_req       = 1'b0;
      i_cmd       = csr_pkg::CMD_CSRRW;
      i_addr      = '0;
      i_wdata     = '0;
      i_trap_kind = csr_pkg::TK_IRQ;
      i_mtip      = 1'b0;
      i_dbg_halt  = 1'b0;
      i_dbg_reset = 1'b0;
      {m_mie, m_mpie, m_mtie, m_mtip, m_cause31, m_step, m_ebreakm, m_tir, m_new_irq} = '0;
      m_code     = '0;
      m_dcause   = '0;
      m_mscratch = '0;
      m_mtvec    = '0;
      m_mepc     = '0;
      repeat (4) @(posedge i_clk);
      i_rst_n <= 1'b1;
      @(negedge i_clk);
      check("ack after reset", 32'h0, {31'b0, o_ack});
      check_flags("after reset");

      // mscratch and mtvec interleaved, each old value shows the previous op
      for (int k = 0; k < 16; k++) begin
         r = $random(seed);
         d = $random(seed);
         run_cmd($sformatf("rmw %0d", k), rmw_op(r[1:0]),
                 k[0] ? `CSR_A_MTVEC : `CSR_A_MSCRATCH, d, csr_pkg::TK_IRQ);
      end
      read_csr("mscratch final", `CSR_A_MSCRATCH);
      read_csr("mtvec final", `CSR_A_MTVEC);

      // masks of the narrow csrs
      write_csr("mstatus ones", `CSR_A_MSTATUS, 32'hffff_ffff);
      read_csr("mstatus mask", `CSR_A_MSTATUS);
      run_cmd("mstatus clr", csr_pkg::CMD_CSRRC, `CSR_A_MSTATUS, 32'hffff_ffff, csr_pkg::TK_IRQ);
      read_csr("mstatus zero", `CSR_A_MSTATUS);
      write_csr("mie ones", `CSR_A_MIE, 32'hffff_ffff);
      run_cmd("mie clr", csr_pkg::CMD_CSRRC, `CSR_A_MIE, 32'hffff_ffff, csr_pkg::TK_IRQ);
      read_csr("mie zero", `CSR_A_MIE);
      write_csr("misa write", `CSR_A_MISA, 32'h0);
      read_csr("misa fixed", `CSR_A_MISA);
      write_csr("mcause ones", `CSR_A_MCAUSE, 32'hffff_ffff);
      read_csr("mcause mask", `CSR_A_MCAUSE);
      write_csr("mcause zero", `CSR_A_MCAUSE, 32'h0);

      // one trap of each synchronous kind, then mret
      write_csr("mtvec base", `CSR_A_MTVEC, $random(seed));
      run_cmd("mie on", csr_pkg::CMD_CSRRS, `CSR_A_MSTATUS, 32'h8, csr_pkg::TK_IRQ);
      for (int k = 1; k <= 5; k++) begin
         kind = csr_pkg::trap_kind_e'(k[2:0]);
         run_cmd({"trap ", kind.name()}, csr_pkg::CMD_TRAP, 12'h000, $random(seed), kind);
         read_csr({"mcause ", kind.name()}, `CSR_A_MCAUSE);
         read_csr({"mepc ", kind.name()}, `CSR_A_MEPC);
         read_csr({"mstatus in trap ", kind.name()}, `CSR_A_MSTATUS);
         run_cmd({"mret ", kind.name()}, csr_pkg::CMD_MRET, 12'h000, 32'h0, csr_pkg::TK_IRQ);
         read_csr({"mstatus after mret ", kind.name()}, `CSR_A_MSTATUS);
      end

      // timer interrupt edge and irq trap
      drive_mtip(1'b1);
      write_csr("mtie on", `CSR_A_MIE, 32'h80);
      check_flags("irq rise");
      run_cmd("trap irq", csr_pkg::CMD_TRAP, 12'h000, $random(seed), csr_pkg::TK_IRQ);
      check_flags("irq fall");
      read_csr("mcause irq", `CSR_A_MCAUSE);
      run_cmd("mret irq", csr_pkg::CMD_MRET, 12'h000, 32'h0, csr_pkg::TK_IRQ);
      drive_mtip(1'b0);

      // dcsr step, ebreakm and cause
      write_csr("dcsr step", `CSR_A_DCSR, 32'h0000_8004);
      check_flags("step on");
      read_csr("dcsr read", `CSR_A_DCSR);
      run_cmd("dcsr step clr", csr_pkg::CMD_CSRRC, `CSR_A_DCSR, 32'h4, csr_pkg::TK_IRQ);
      check_flags("step off");
      pulse_halt();
      read_csr("dcsr halt cause", `CSR_A_DCSR);
      run_cmd("dret", csr_pkg::CMD_DRET, 12'h000, 32'h0, csr_pkg::TK_IRQ);
      read_csr("dcsr after dret", `CSR_A_DCSR);
      run_cmd("trap ebreak dbg", csr_pkg::CMD_TRAP, 12'h000, $random(seed), csr_pkg::TK_EBREAK);
      read_csr("dcsr ebreak cause", `CSR_A_DCSR);

      // debug reset clears the serial state but not the storage
      write_csr("dcsr step again", `CSR_A_DCSR, 32'h0000_8004);
      write_csr("mtie again", `CSR_A_MIE, 32'h80);
      drive_mtip(1'b1);
      write_csr("mie again", `CSR_A_MSTATUS, 32'h8);
      check_flags("before dbg reset");
      pulse_dbg_reset();
      check_flags("after dbg reset");
      read_csr("dcsr after dbg reset", `CSR_A_DCSR);
      read_csr("mie after dbg reset", `CSR_A_MIE);
      read_csr("mscratch kept", `CSR_A_MSCRATCH);
      drive_mtip(1'b0);

      @(negedge i_clk);
      if (exp_q.size() == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("%0d commands never got an ack", exp_q.size());
         $display("Verification failed");
         $fatal(1, "missing acks");
      end
   end

endmodule

// File: vlog.f
+incdir+design
design/csr_pkg.sv
design/csr_ctrl.sv
design/serial_csr.sv
design/csr_store.sv
design/csr_top.sv
verif/tb_csr_top.sv
